/* files.f */
+incdir+rtl
rtl/pci_pkg.sv
rtl/pci_initiator.sv
rtl/pci_target.sv
rtl/pci_bus_port.sv
rtl/pci_device.sv
sim/tb_pci_device.sv

/* run.sh */
#!/bin/sh
# build and run the bus device testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_pci_device \
        -Mdir obj_dir -o tb_pci_device
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/tb_pci_device > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
        echo "simulation exited with status $run_status"
        exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
        exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* sim/tb_pci_device.sv */
`timescale 1ns/1ps
`include "pci_macros.svh"

module tb_pci_device;
        logic clk, rst_n, start, load_en, gnt_n;
        pci_pkg::pci_cmd_t cmd;
        pci_pkg::pci_word_t addr, load_data, d_rd_data, d_ad_out, b_ad, p_ad;
        logic [`PCI_CNT_W-1:0] count;
        logic [`PCI_IDX_W-1:0] load_idx;
        logic [`PCI_ID_W-1:0] dev_id;
        logic d_rd_valid, d_done, d_req_n, d_ad_oe, d_cbe_out, d_cbe_oe;
        logic d_frame_out, d_frame_oe, d_irdy_out, d_irdy_oe;
        logic d_trdy_out, d_trdy_oe, d_devsel_out, d_devsel_oe;
        logic b_cbe, b_frame, b_irdy, b_trdy, b_devsel, p_ad_oe;
        // partner initiator and partner target drive requests
        logic pi_oe, pi_frame, pi_irdy, pi_cbe, pi_ad_oe;
        pci_pkg::pci_word_t pi_ad, pt_ad;
        logic pt_oe, pt_trdy, pt_devsel, pt_ad_oe, pt_cmd, pt_frame_q;
        logic [1:0] pt_state;
        logic [`PCI_IDX_W-1:0] pt_idx;
        // bus snapshot taken mid-cycle
        pci_pkg::pci_word_t s_ad;
        logic s_cbe, s_frame, s_irdy, s_trdy, s_devsel, s_done, prev_d_oe, prev_p_oe;
        pci_pkg::pci_word_t p_mem [`PCI_BURST_MAX];
        // expected partner memory after a DUT initiator write
        pci_pkg::pci_word_t p_exp [`PCI_BURST_MAX];
        pci_pkg::pci_word_t shadow [`PCI_BURST_MAX];
        pci_pkg::pci_word_t wbuf [`PCI_BURST_MAX];
        pci_pkg::pci_word_t rd_q [$];
        integer seed = 20501;
        integer errors = 0, tests = 0, failed = 0, cycles = 0, mark, i, r;

        pci_device i_dut (
                .clk(clk), .rst_n(rst_n), .start(start), .cmd(cmd), .addr(addr),
                .count(count), .load_en(load_en), .load_idx(load_idx),
                .load_data(load_data), .rd_valid(d_rd_valid), .rd_data(d_rd_data),
                .done(d_done), .req_n(d_req_n), .gnt_n(gnt_n), .dev_id(dev_id),
                .ad_in(b_ad), .ad_out(d_ad_out), .ad_oe(d_ad_oe),
                .cbe_in(b_cbe), .cbe_out(d_cbe_out), .cbe_oe(d_cbe_oe),
                .frame_n_in(b_frame), .frame_n_out(d_frame_out), .frame_n_oe(d_frame_oe),
                .irdy_n_in(b_irdy), .irdy_n_out(d_irdy_out), .irdy_n_oe(d_irdy_oe),
                .trdy_n_in(b_trdy), .trdy_n_out(d_trdy_out), .trdy_n_oe(d_trdy_oe),
                .devsel_n_in(b_devsel), .devsel_n_out(d_devsel_out),
                .devsel_n_oe(d_devsel_oe));

        // resolve each split signal, pulled high when nobody drives
        assign p_ad_oe  = pt_ad_oe | pi_ad_oe;
        assign p_ad     = pt_ad_oe ? pt_ad : pi_ad;
        assign b_ad     = d_ad_oe ? d_ad_out : (p_ad_oe ? p_ad : '1);
        assign b_cbe    = d_cbe_oe ? d_cbe_out : (pi_oe ? pi_cbe : 1'b1);
        assign b_frame  = d_frame_oe ? d_frame_out : (pi_oe ? pi_frame : 1'b1);
        assign b_irdy   = d_irdy_oe ? d_irdy_out : (pi_oe ? pi_irdy : 1'b1);
        assign b_trdy   = d_trdy_oe ? d_trdy_out : (pt_oe ? pt_trdy : 1'b1);
        assign b_devsel = d_devsel_oe ? d_devsel_out : (pt_oe ? pt_devsel : 1'b1);

        initial
        begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        always @(posedge clk)
        begin
                cycles = cycles + 1;
                if (cycles >= 2000)
                begin
                        $display("timeout: run did not finish within 2000 cycles");
                        $display("STATUS: FAIL");
                        $finish;
                end
        end

        // true means insert a wait state, about one cycle in four
        function automatic logic rand_wait();
                integer v;
                v = $random(seed);
                return (v[1:0] == 2'b00);
        endfunction

        task automatic check_word(input string name, input pci_pkg::pci_word_t exp,
                                  input pci_pkg::pci_word_t got);
                assert (exp === got)
                else
                begin
                        $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
                        errors = errors + 1;
                end
        endtask

        task automatic end_test(input string name);
                tests = tests + 1;
                if (errors == mark)
                        $display("test %0d %s: ok", tests, name);
                else
                begin
                        failed = failed + 1;
                        $display("test %0d %s: failed", tests, name);
                end
                mark = errors;
        endtask

        // mid-cycle sampling, plus read capture and ad ownership checks
        always @(negedge clk)
        begin
                s_ad = b_ad;
                s_cbe = b_cbe;
                s_frame = b_frame;
                s_irdy = b_irdy;
                s_trdy = b_trdy;
                s_devsel = b_devsel;
                s_done = d_done;
                if (rst_n)
                begin
                        if (d_rd_valid)
                                rd_q.push_back(d_rd_data);
                        assert (!(d_ad_oe && p_ad_oe))
                        else
                        begin
                                $display("Fail at %0t: DUT and partner both drive ad", $time);
                                errors = errors + 1;
                        end
                        assert (!(prev_p_oe && !p_ad_oe && d_ad_oe) &&
                                !(prev_d_oe && !d_ad_oe && p_ad_oe))
                        else
                        begin
                                $display("Fail at %0t: ad driven with no turnaround cycle", $time);
                                errors = errors + 1;
                        end
                end
                prev_d_oe = d_ad_oe;
                prev_p_oe = p_ad_oe;
        end

        // partner target at id 1, always claims with random trdy_n waits
        always @(posedge clk)
        begin
                #1;
                if (!rst_n)
                begin
                        pt_state = 2'd0;
                        pt_oe = 1'b0;
                        pt_ad_oe = 1'b0;
                        pt_trdy = 1'b1;
                        pt_devsel = 1'b1;
                end
                else
                begin
                        case (pt_state)
                        2'd0:
                        begin
                                if (pt_frame_q && !s_frame && s_ad[31:30] == 2'd1)
                                begin
                                        pt_cmd = s_cbe;
                                        pt_idx = s_ad[4:2];
                                        pt_oe = 1'b1;
                                        pt_devsel = 1'b0;
                                        pt_trdy = s_cbe ? 1'b1 : rand_wait();
                                        pt_state = s_cbe ? 2'd1 : 2'd2;
                                end
                        end
                        2'd1:
                        begin
                                pt_state = 2'd2;
                                pt_ad_oe = 1'b1;
                                pt_ad = p_mem[pt_idx];
                                pt_trdy = rand_wait();
                        end
                        2'd2:
                        begin
                                if (!s_irdy && !s_trdy)
                                begin
                                        if (!pt_cmd)
                                                p_mem[pt_idx] = s_ad;
                                        pt_idx = pt_idx + 1'b1;
                                        pt_ad = p_mem[pt_idx];
                                end
                                if (!s_irdy && !s_trdy && s_frame)
                                begin
                                        pt_state = 2'd3;
                                        pt_trdy = 1'b1;
                                        pt_devsel = 1'b1;
                                        pt_ad_oe = 1'b0;
                                end
                                else
                                        pt_trdy = rand_wait();
                        end
                        default:
                        begin
                                pt_state = 2'd0;
                                pt_oe = 1'b0;
                        end
                        endcase
                end
                pt_frame_q = s_frame;
        end

        task automatic wait_done();
                while (!s_done)
                        @(posedge clk);
        endtask

        task automatic host_start(input pci_pkg::pci_cmd_t c, input logic [2:0] idx,
                                  input logic [3:0] n);
                @(posedge clk);
                #1;
                start = 1'b1;
                cmd = c;
                addr = {2'b01, 25'd0, idx, 2'b00};
                count = n;
                @(posedge clk);
                #1;
                start = 1'b0;
                wait_done();
        endtask

        task automatic host_write(input logic [2:0] idx, input logic [3:0] n);
                logic [3:0] k;
                logic [2:0] j;
                for (k = 0; k < n; k = k + 1)
                begin
                        wbuf[k[2:0]] = $random(seed);
                        @(posedge clk);
                        #1;
                        load_en = 1'b1;
                        load_idx = k[2:0];
                        load_data = wbuf[k[2:0]];
                end
                @(posedge clk);
                #1;
                load_en = 1'b0;
                for (i = 0; i < 8; i = i + 1)
                        p_exp[i] = p_mem[i];
                for (k = 0; k < n; k = k + 1)
                begin
                        j = idx + k[2:0];
                        p_exp[j] = wbuf[k[2:0]];
                end
                host_start(pci_pkg::CMD_WRITE, idx, n);
                for (i = 0; i < 8; i = i + 1)
                        check_word("partner memory", p_exp[i], p_mem[i]);
        endtask

        task automatic host_read(input logic [2:0] idx, input logic [3:0] n);
                logic [3:0] k;
                logic [2:0] j;
                rd_q.delete();
                host_start(pci_pkg::CMD_READ, idx, n);
                check_word("read word count", 32'(n), 32'(rd_q.size()));
                for (k = 0; k < n && int'(k) < rd_q.size(); k = k + 1)
                begin
                        j = idx + k[2:0];
                        check_word("rd_data", p_mem[j], rd_q[k]);
                end
                @(posedge clk);
                check_word("irdy_n after done", 32'd1, {31'd0, s_irdy});
        endtask

        // partner initiator burst at the given id, reads are checked against shadow
        task automatic partner_burst(input logic wr, input logic [1:0] id,
                                     input logic [2:0] idx, input logic [3:0] n);
                logic [3:0] k;
                logic [2:0] j;
                @(posedge clk);
                #1;
                pi_oe = 1'b1;
                pi_frame = 1'b0;
                pi_irdy = 1'b1;
                pi_cbe = !wr;
                pi_ad = {id, 25'd0, idx, 2'b00};
                pi_ad_oe = 1'b1;
                @(posedge clk);
                #1;
                pi_ad_oe = wr;
                if (!wr)
                begin
                        @(posedge clk);
                        #1;
                end
                k = 0;
                while (k < n)
                begin
                        j = idx + k[2:0];
                        pi_irdy = rand_wait();
                        pi_frame = !pi_irdy && (k == n - 1'b1);
                        if (wr)
                                pi_ad = $random(seed);
                        @(posedge clk);
                        if (!s_irdy && !s_trdy && !s_devsel)
                        begin
                                if (wr)
                                        shadow[j] = pi_ad;
                                else
                                        check_word("DUT target read data", shadow[j], s_ad);
                                k = k + 1'b1;
                        end
                        #1;
                end
                pi_frame = 1'b1;
                pi_irdy = 1'b1;
                pi_ad_oe = 1'b0;
                @(posedge clk);
                #1;
                pi_oe = 1'b0;
        endtask

        // address for id 3, the DUT must stay off devsel_n and trdy_n
        task automatic probe_foreign();
                @(posedge clk);
                #1;
                pi_oe = 1'b1;
                pi_frame = 1'b0;
                pi_cbe = 1'b0;
                pi_ad = {2'd3, 30'h15};
                pi_ad_oe = 1'b1;
                @(posedge clk);
                #1;
                pi_frame = 1'b1;
                pi_irdy = 1'b0;
                pi_ad = 32'h5a5a_0f0f;
                repeat (4)
                begin
                        @(negedge clk);
                        assert (!d_devsel_oe && !d_trdy_oe)
                        else
                        begin
                                $display("Fail at %0t: DUT claimed a foreign address", $time);
                                errors = errors + 1;
                        end
                        @(posedge clk);
                        #1;
                        pi_irdy = 1'b1;
                        pi_ad_oe = 1'b0;
                        pi_oe = 1'b0;
                end
        endtask

        initial
        begin
                rst_n = 1'b0;
                start = 1'b0;
                cmd = pci_pkg::CMD_WRITE;
                addr = '0;
                count = '0;
                load_en = 1'b0;
                load_idx = '0;
                load_data = '0;
                gnt_n = 1'b0;
                dev_id = 2'd2;
                pi_oe = 1'b0;
                pi_frame = 1'b1;
                pi_irdy = 1'b1;
                pi_cbe = 1'b1;
                pi_ad = '0;
                pi_ad_oe = 1'b0;
                pt_state = 2'd0;
                pt_oe = 1'b0;
                pt_ad_oe = 1'b0;
                pt_trdy = 1'b1;
                pt_devsel = 1'b1;
                pt_ad = '0;
                pt_cmd = 1'b0;
                pt_idx = '0;
                pt_frame_q = 1'b1;
                prev_d_oe = 1'b0;
                prev_p_oe = 1'b0;
                mark = 0;
                for (i = 0; i < 8; i = i + 1)
                        p_mem[i] = $random(seed);
                repeat (9) @(posedge clk);
                @(negedge clk);
                check_word("oe and pulse outputs", 32'd0,
                           {25'd0, d_ad_oe, d_cbe_oe, d_frame_oe, d_irdy_oe,
                            d_trdy_oe, d_devsel_oe, d_done | d_rd_valid});
                check_word("req_n", 32'd1, {31'd0, d_req_n});
                end_test("reset values");
                @(posedge clk);
                #1;
                rst_n = 1'b1;
                r = $random(seed);
                host_write(r[2:0], 4'(r[5:3]) + 4'd1);
                end_test("DUT initiator write");
                r = $random(seed);
                host_read(r[2:0], 4'(r[5:3]) + 4'd1);
                end_test("DUT initiator read");
                r = $random(seed);
                partner_burst(1'b1, 2'd2, r[2:0], 4'd8);
                partner_burst(1'b0, 2'd2, r[5:3], 4'd8);
                end_test("partner write and read of DUT target");
                probe_foreign();
                partner_burst(1'b0, 2'd2, 3'd0, 4'd8);
                end_test("non-matching id ignored");
                repeat (3)
                begin
                        r = $random(seed);
                        host_write(r[2:0], 4'(r[5:3]) + 4'd1);
                        host_read(r[8:6], 4'(r[11:9]) + 4'd1);
                        partner_burst(1'b1, 2'd2, r[14:12], 4'(r[17:15]) + 4'd1);
                        partner_burst(1'b0, 2'd2, r[20:18], 4'd8);
                end
                end_test("mixed bursts with wait states");
                $display("%0d tests, %0d failed, %0d check errors", tests, failed, errors);
                if (errors == 0)
                        $display("STATUS: PASS");
                else
                        $display("STATUS: FAIL");
                $finish;
        end

endmodule

/* rtl/pci_device.sv */
`timescale 1ns/1ps
`include "pci_macros.svh"

module pci_device
(
        input  logic                    clk,
        input  logic                    rst_n,
        // host side
        input  logic                    start,
        input  pci_pkg::pci_cmd_t       cmd,
        input  pci_pkg::pci_word_t      addr,
        input  logic [`PCI_CNT_W-1:0]   count,
        input  logic                    load_en,
        input  logic [`PCI_IDX_W-1:0]   load_idx,
        input  pci_pkg::pci_word_t      load_data,
        output logic                    rd_valid,
        output pci_pkg::pci_word_t      rd_data,
        output logic                    done,
        output logic                    req_n,
        input  logic                    gnt_n,
        input  logic [`PCI_ID_W-1:0]    dev_id,
        // split bus pins
        input  pci_pkg::pci_word_t      ad_in,
        output pci_pkg::pci_word_t      ad_out,
        output logic                    ad_oe,
        input  logic                    cbe_in,
        output logic                    cbe_out,
        output logic                    cbe_oe,
        input  logic                    frame_n_in,
        output logic                    frame_n_out,
        output logic                    frame_n_oe,
        input  logic                    irdy_n_in,
        output logic                    irdy_n_out,
        output logic                    irdy_n_oe,
        input  logic                    trdy_n_in,
        output logic                    trdy_n_out,
        output logic                    trdy_n_oe,
        input  logic                    devsel_n_in,
        output logic                    devsel_n_out,
        output logic                    devsel_n_oe
);
        // initiator drive requests
        pci_pkg::pci_word_t             m_ad_out;
        logic                           m_ad_oe;
        logic                           m_cbe_out;
        logic                           m_frame_n;
        logic                           m_irdy_n;
        logic                           m_drive;

        // target drive requests
        pci_pkg::pci_word_t             t_ad_out;
        logic                           t_ad_oe;
        logic                           t_trdy_n;
        logic                           t_devsel_n;
        logic                           t_drive;

        logic                           bus_idle;

        pci_initiator i_initiator (.*);

        pci_target i_target (.*);

        // owns the pins, both roles only request
        pci_bus_port i_bus_port (.*);

endmodule

/* rtl/pci_bus_port.sv */
`timescale 1ns/1ps
`include "pci_macros.svh"

module pci_bus_port
(
        input  logic                    clk,
        input  logic                    rst_n,
        input  pci_pkg::pci_word_t      m_ad_out,
        input  logic                    m_ad_oe,
        input  logic                    m_cbe_out,
        input  logic                    m_frame_n,
        input  logic                    m_irdy_n,
        input  logic                    m_drive,
        input  pci_pkg::pci_word_t      t_ad_out,
        input  logic                    t_ad_oe,
        input  logic                    t_trdy_n,
        input  logic                    t_devsel_n,
        input  logic                    t_drive,
        input  logic                    frame_n_in,
        input  logic                    irdy_n_in,
        output logic                    bus_idle,
        output pci_pkg::pci_word_t      ad_out,
        output logic                    ad_oe,
        output logic                    cbe_out,
        output logic                    cbe_oe,
        output logic                    frame_n_out,
        output logic                    frame_n_oe,
        output logic                    irdy_n_out,
        output logic                    irdy_n_oe,
        output logic                    trdy_n_out,
        output logic                    trdy_n_oe,
        output logic                    devsel_n_out,
        output logic                    devsel_n_oe
);
        logic                           ad_oe_q;
        logic                           released;
        logic                           turn_q;
        logic                           idle_q;

        // ad belongs to whichever role asks, never both
        assign ad_out       = m_ad_oe ? m_ad_out : t_ad_out;
        assign ad_oe        = m_ad_oe | t_ad_oe;

        assign cbe_out      = m_cbe_out;
        assign cbe_oe       = m_drive;
        assign frame_n_out  = m_frame_n;
        assign frame_n_oe   = m_drive;
        assign irdy_n_out   = m_irdy_n;
        assign irdy_n_oe    = m_drive;
        assign trdy_n_out   = t_trdy_n;
        assign trdy_n_oe    = t_drive;
        assign devsel_n_out = t_devsel_n;
        assign devsel_n_oe  = t_drive;

        assign released     = ad_oe_q && !ad_oe;

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        ad_oe_q <= 1'b0;
                        turn_q  <= 1'b0;
                        idle_q  <= 1'b0;
                end
                else
                begin
                        ad_oe_q <= ad_oe;
                        turn_q  <= released;
                        idle_q  <= frame_n_in && irdy_n_in;
                end
        end

        // idle needs frame_n and irdy_n high last cycle and no ad turnaround pending
        assign bus_idle = idle_q && !turn_q;

        a_single_owner: assert property (@(posedge clk) disable iff (!rst_n)
                !(m_ad_oe && t_ad_oe));

        a_ad_turnaround: assert property (@(posedge clk) disable iff (!rst_n)
                $fell(ad_oe) |=> !ad_oe);

endmodule

/* rtl/pci_target.sv */
`timescale 1ns/1ps
`include "pci_macros.svh"

module pci_target
(
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic [`PCI_ID_W-1:0]    dev_id,
        input  pci_pkg::pci_word_t      ad_in,
        input  logic                    cbe_in,
        input  logic                    frame_n_in,
        input  logic                    irdy_n_in,
        output pci_pkg::pci_word_t      t_ad_out,
        output logic                    t_ad_oe,
        output logic                    t_trdy_n,
        output logic                    t_devsel_n,
        output logic                    t_drive
);
        pci_pkg::tgt_phase_t            phase;
        pci_pkg::pci_cmd_t              cmd_q;
        logic [`PCI_IDX_W-1:0]          idx;
        logic                           frame_q;
        logic                           addr_hit;
        logic                           xfer;
        pci_pkg::pci_word_t             mem [`PCI_BURST_MAX];

        // address phase is the cycle frame_n falls, id sits in the top bits
        assign addr_hit = frame_q && !frame_n_in &&
                          (ad_in[`PCI_AD_W-1 -: `PCI_ID_W] == dev_id);
        // always ready, so any irdy_n low in T_DATA moves a word
        assign xfer     = (phase == pci_pkg::T_DATA) && !irdy_n_in;

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        phase   <= pci_pkg::T_IDLE;
                        cmd_q   <= pci_pkg::CMD_WRITE;
                        idx     <= '0;
                        frame_q <= 1'b1;
                end
                else
                begin
                        frame_q <= frame_n_in;
                        case (phase)
                        pci_pkg::T_IDLE:
                        begin
                                if (addr_hit)
                                begin
                                        cmd_q <= pci_pkg::pci_cmd_t'(cbe_in);
                                        idx   <= ad_in[`PCI_IDX_W+1:2];
                                        // reads need a turnaround before we drive ad
                                        phase <= (cbe_in == pci_pkg::CMD_READ) ?
                                                 pci_pkg::T_TURN : pci_pkg::T_DATA;
                                end
                        end
                        pci_pkg::T_TURN:
                                phase <= pci_pkg::T_DATA;
                        pci_pkg::T_DATA:
                        begin
                                if (xfer)
                                begin
                                        // index wraps at 8
                                        idx <= idx + 1'b1;
                                        if (frame_n_in)
                                                phase <= pci_pkg::T_RECOVER;
                                end
                        end
                        default:
                                phase <= pci_pkg::T_IDLE;
                        endcase
                end
        end

        always_ff @(posedge clk)
        begin
                if (xfer && (cmd_q == pci_pkg::CMD_WRITE))
                        mem[idx] <= ad_in;
        end

        // T_RECOVER drives devsel_n and trdy_n high for one cycle before release
        assign t_drive    = (phase != pci_pkg::T_IDLE);
        assign t_devsel_n = !((phase == pci_pkg::T_TURN) || (phase == pci_pkg::T_DATA));
        assign t_trdy_n   = (phase != pci_pkg::T_DATA);
        assign t_ad_oe    = (phase == pci_pkg::T_DATA) && (cmd_q == pci_pkg::CMD_READ);
        assign t_ad_out   = mem[idx];

        // trdy_n only inside a claimed transaction that the initiator still holds
        a_trdy_claimed: assert property (@(posedge clk) disable iff (!rst_n)
                !t_trdy_n |-> !t_devsel_n && !(frame_n_in && irdy_n_in));

endmodule

/* rtl/pci_initiator.sv */
`timescale 1ns/1ps
`include "pci_macros.svh"

module pci_initiator
(
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    start,
        input  pci_pkg::pci_cmd_t       cmd,
        input  pci_pkg::pci_word_t      addr,
        input  logic [`PCI_CNT_W-1:0]   count,
        input  logic                    load_en,
        input  logic [`PCI_IDX_W-1:0]   load_idx,
        input  pci_pkg::pci_word_t      load_data,
        input  logic                    gnt_n,
        input  logic                    bus_idle,
        input  pci_pkg::pci_word_t      ad_in,
        input  logic                    trdy_n_in,
        input  logic                    devsel_n_in,
        output logic                    req_n,
        output logic                    rd_valid,
        output pci_pkg::pci_word_t      rd_data,
        output logic                    done,
        output pci_pkg::pci_word_t      m_ad_out,
        output logic                    m_ad_oe,
        output logic                    m_cbe_out,
        output logic                    m_frame_n,
        output logic                    m_irdy_n,
        output logic                    m_drive
);
        pci_pkg::mst_phase_t            phase;
        pci_pkg::pci_cmd_t              cmd_q;
        pci_pkg::pci_word_t             addr_q;
        logic [`PCI_CNT_W-1:0]          count_q;
        logic [`PCI_CNT_W-1:0]          cnt;
        logic [`PCI_IDX_W-1:0]          buf_idx;
        pci_pkg::pci_word_t             burst_buf [`PCI_BURST_MAX];
        logic                           is_read;
        logic                           last;
        logic                           xfer;
        logic                           accept;

        // a new start only counts while idle with no request pending
        assign accept  = (phase == pci_pkg::M_IDLE) && req_n && start;
        assign is_read = (cmd_q == pci_pkg::CMD_READ);
        assign buf_idx = cnt[`PCI_IDX_W-1:0];
        assign last    = (cnt == count_q - 1'b1);
        // our irdy_n is low throughout M_DATA
        assign xfer    = (phase == pci_pkg::M_DATA) && !trdy_n_in && !devsel_n_in;

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        phase    <= pci_pkg::M_IDLE;
                        req_n    <= 1'b1;
                        cnt      <= '0;
                        rd_valid <= 1'b0;
                end
                else
                begin
                        rd_valid <= 1'b0;
                        case (phase)
                        pci_pkg::M_IDLE:
                        begin
                                if (accept)
                                        req_n <= 1'b0;
                                else if (!req_n && !gnt_n && bus_idle)
                                begin
                                        // bus is ours, address goes out next cycle
                                        req_n <= 1'b1;
                                        cnt   <= '0;
                                        phase <= pci_pkg::M_ADDR;
                                end
                        end
                        pci_pkg::M_ADDR:
                                phase <= is_read ? pci_pkg::M_TURN : pci_pkg::M_DATA;
                        pci_pkg::M_TURN:
                                phase <= pci_pkg::M_DATA;
                        pci_pkg::M_DATA:
                        begin
                                if (xfer)
                                begin
                                        cnt      <= cnt + 1'b1;
                                        rd_valid <= is_read;
                                        if (last)
                                                phase <= pci_pkg::M_DONE;
                                end
                        end
                        default:
                                phase <= pci_pkg::M_IDLE;
                        endcase
                end
        end

        // request parameters, captured with the start strobe
        always_ff @(posedge clk)
        begin
                if (accept)
                begin
                        cmd_q   <= cmd;
                        addr_q  <= addr;
                        count_q <= count;
                end
        end

        // burst buffer: host loads write data, reads land here as well
        always_ff @(posedge clk)
        begin
                if (xfer && is_read)
                begin
                        burst_buf[buf_idx] <= ad_in;
                        rd_data            <= ad_in;
                end
                else if (load_en)
                        burst_buf[load_idx] <= load_data;
        end

        // keeps driving in M_DONE so frame_n/irdy_n are seen high before release
        assign m_drive   = (phase != pci_pkg::M_IDLE);
        assign m_frame_n = !((phase == pci_pkg::M_ADDR) || (phase == pci_pkg::M_TURN) ||
                             ((phase == pci_pkg::M_DATA) && !last));
        assign m_irdy_n  = (phase != pci_pkg::M_DATA);
        assign m_ad_oe   = (phase == pci_pkg::M_ADDR) ||
                           ((phase == pci_pkg::M_DATA) && !is_read);
        assign m_ad_out  = (phase == pci_pkg::M_ADDR) ? addr_q : burst_buf[buf_idx];
        assign m_cbe_out = cmd_q;
        assign done      = (phase == pci_pkg::M_DONE);

        // frame_n only starts a transaction straight out of idle
        a_frame_fall: assert property (@(posedge clk) disable iff (!rst_n)
                $fell(m_frame_n) |-> (phase == pci_pkg::M_ADDR) &&
                                     ($past(phase) == pci_pkg::M_IDLE));

endmodule

/* rtl/pci_pkg.sv */
`include "pci_macros.svh"

package pci_pkg;

        // one address or data word on ad
        typedef logic [`PCI_AD_W-1:0] pci_word_t;

        // command sent on cbe during the address phase
        typedef enum logic
        {
                CMD_WRITE = 1'b0,
                CMD_READ  = 1'b1
        } pci_cmd_t;

        typedef enum logic [2:0]
        {
                M_IDLE,
                M_ADDR,
                M_TURN,
                M_DATA,
                M_DONE
        } mst_phase_t;

        typedef enum logic [1:0]
        {
                T_IDLE,
                T_TURN,
                T_DATA,
                T_RECOVER
        } tgt_phase_t;

endpackage

/* rtl/pci_macros.svh */
`ifndef PCI_MACROS_SVH
`define PCI_MACROS_SVH

// address/data width of the shared bus
`define PCI_AD_W        32

// longest burst, also the depth of the burst buffer and target memory
`define PCI_BURST_MAX   8
`define PCI_IDX_W       3

// burst length field, holds 1..8
`define PCI_CNT_W       4

// device id, compared against ad[31:30] in the address phase
`define PCI_ID_W        2

`endif
